// File: compile.f
hdl/lsu_pkg.sv
hdl/ls_queue.sv
hdl/ls_unit.sv
hdl/data_mem.sv
hdl/lsu_top.sv
test/lsu_top_tb.sv

// File: run.sh
#!/bin/sh
# build and run the lsu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module lsu_top_tb \
    -f compile.f -Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

// File: test/lsu_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top_tb;
    import lsu_pkg::*;

    localparam int QUEUE_DEPTH  = 4;
    localparam int MEM_WORDS    = 256;
    localparam int MISS_CYCLES  = 4;
    localparam int NUM_OPS      = 30;
    localparam int BP_START     = 22;  // first op dispatched with writeback stalled
    localparam int STALL_WINDOW = 40;
    localparam int HS_TIMEOUT   = 200;
    localparam int IDLE_LIMIT   = 100;

    // command, func, func3, base, store data, imm, tag
    localparam ls_insn_t OPS [NUM_OPS] = '{
        '{bus_store, ls_load,  3'b010, 32'h0000_0100, 32'h8765_43a1, 32'h0000_0000, 5'd1},
        '{bus_load,  ls_load,  3'b010, 32'h0000_0108, 32'h0000_0000, 32'hffff_fff8, 5'd2},
        '{bus_load,  ls_load,  3'b000, 32'h0000_0100, 32'h0000_0000, 32'h0000_0000, 5'd3},
        '{bus_load,  ls_load,  3'b000, 32'h0000_00fc, 32'h0000_0000, 32'h0000_0005, 5'd4},
        '{bus_load,  ls_load,  3'b000, 32'h0000_0102, 32'h0000_0000, 32'h0000_0000, 5'd5},
        '{bus_load,  ls_load,  3'b000, 32'h0000_0103, 32'h0000_0000, 32'h0000_0000, 5'd6},
        '{bus_load,  ls_loadu, 3'b100, 32'h0000_0100, 32'h0000_0000, 32'h0000_0000, 5'd7},
        '{bus_load,  ls_loadu, 3'b100, 32'h0000_0103, 32'h0000_0000, 32'h0000_0000, 5'd8},
        '{bus_load,  ls_load,  3'b001, 32'h0000_0100, 32'h0000_0000, 32'h0000_0000, 5'd9},
        '{bus_load,  ls_load,  3'b001, 32'h0000_0110, 32'h0000_0000, 32'hffff_fff2, 5'd10},
        '{bus_load,  ls_loadu, 3'b101, 32'h0000_0102, 32'h0000_0000, 32'h0000_0000, 5'd11},
        '{bus_store, ls_load,  3'b000, 32'h0000_0101, 32'h1234_565c, 32'h0000_0000, 5'd12},
        '{bus_store, ls_load,  3'b001, 32'h0000_0102, 32'habcd_f00d, 32'h0000_0000, 5'd13},
        '{bus_load,  ls_load,  3'b010, 32'h0000_0100, 32'h0000_0000, 32'h0000_0000, 5'd14},
        '{bus_load,  ls_loadu, 3'b100, 32'h0000_0101, 32'h0000_0000, 32'h0000_0000, 5'd15},
        '{bus_store, ls_load,  3'b010, 32'h0000_0200, 32'h1357_9bdf, 32'h0000_0000, 5'd16},
        '{bus_store, ls_load,  3'b010, 32'h0000_0380, 32'h2468_ace0, 32'h0000_0000, 5'd17},
        '{bus_load,  ls_load,  3'b010, 32'h0000_0200, 32'h0000_0000, 32'h0000_0000, 5'd18},
        '{bus_load,  ls_loadu, 3'b101, 32'h0000_0202, 32'h0000_0000, 32'h0000_0000, 5'd19},
        '{bus_load,  ls_load,  3'b010, 32'h0000_0380, 32'h0000_0000, 32'h0000_0000, 5'd20},
        '{bus_load,  ls_load,  3'b000, 32'h0000_0383, 32'h0000_0000, 32'h0000_0000, 5'd21},
        '{bus_load,  ls_load,  3'b010, 32'h0000_0204, 32'h0000_0000, 32'h0000_0000, 5'd22},
        '{bus_store, ls_load,  3'b010, 32'h0000_0040, 32'h1122_3344, 32'h0000_0000, 5'd23},
        '{bus_load,  ls_load,  3'b001, 32'h0000_0042, 32'h0000_0000, 32'h0000_0000, 5'd24},
        '{bus_store, ls_load,  3'b000, 32'h0000_0043, 32'h0000_0099, 32'h0000_0000, 5'd25},
        '{bus_load,  ls_load,  3'b000, 32'h0000_0043, 32'h0000_0000, 32'h0000_0000, 5'd26},
        '{bus_load,  ls_loadu, 3'b101, 32'h0000_0042, 32'h0000_0000, 32'h0000_0000, 5'd27},
        '{bus_store, ls_load,  3'b010, 32'h0000_03f0, 32'hcafe_f00d, 32'h0000_0000, 5'd28},
        '{bus_load,  ls_load,  3'b010, 32'h0000_03f0, 32'h0000_0000, 32'h0000_0000, 5'd29},
        '{bus_load,  ls_load,  3'b000, 32'h0000_03f1, 32'h0000_0000, 32'h0000_0000, 5'd30}
    };

    logic       clock = 1'b0;
    logic       rst;
    logic       disp_req;
    logic       disp_ack;
    ls_insn_t   disp_insn;
    logic       wb_req;
    logic       wb_ack;
    ls_result_t wb_result;

    logic [7:0]  model_mem [MEM_WORDS*4];  // byte view of the data RAM
    ls_result_t  exp_q [$];
    logic [15:0] lfsr = 16'd18650;
    int          value_errors = 0;
    int          timeout_errors = 0;
    logic        stall_wb = 1'b0;
    logic        bp_active = 1'b0;
    logic        bp_blocked = 1'b0;
    int          bp_count = 0;
    logic        all_done = 1'b0;

    lsu_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .MEM_WORDS   (MEM_WORDS),
        .MISS_CYCLES (MISS_CYCLES)
    ) UUT (
        .clock     (clock),
        .rst       (rst),
        .disp_req  (disp_req),
        .disp_ack  (disp_ack),
        .disp_insn (disp_insn),
        .wb_req    (wb_req),
        .wb_ack    (wb_ack),
        .wb_result (wb_result)
    );

    always #50 clock = ~clock;

    // fibonacci lfsr with taps 16 14 13 11
    function automatic int random_bits(input int n);
        int   value;
        logic fb;
        value = 0;
        for (int k = 0; k < n; k++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    // applies one op to the byte model and returns what writeback should carry
    function automatic ls_result_t model_access(input ls_insn_t op);
        logic [31:0] addr;
        int          idx;
        int          nbytes;
        ls_result_t  res;
        addr     = op.value_src1 + op.imm;
        idx      = int'(addr) & (MEM_WORDS*4 - 1);
        nbytes   = 1 << op.func3[1:0];
        res.tag  = op.insn_tag;
        res.data = '0;
        for (int b = 0; b < nbytes; b++) begin
            if (op.mem_command == bus_store) begin
                model_mem[idx+b] = op.value_src2[b*8 +: 8];
            end else begin
                res.data[b*8 +: 8] = model_mem[idx+b];
            end
        end
        if (op.mem_command == bus_load && op.func == ls_load && nbytes < 4) begin
            if (res.data[8*nbytes-1]) begin
                res.data = res.data | ~((32'h1 << (8*nbytes)) - 32'h1); // sign fill
            end
        end
        return res;
    endfunction

    task automatic check_result(input string name, input ls_result_t got,
                                input ls_result_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s got tag %0d data %h, expected tag %0d data %h",
                     $time, name, got.tag, got.data, exp.tag, exp.data);
        end
    endtask

    task automatic check_command(input string name, input bus_command_t got,
                                 input bus_command_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s got %s, expected %s",
                     $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic dispatch(input ls_insn_t op);
        int waited;
        exp_q.push_back(model_access(op));
        @(negedge clock);
        disp_insn = op;
        disp_req  = 1'b1;
        waited    = 0;
        do begin
            @(negedge clock);
            waited++;
            if (bp_active && waited == STALL_WINDOW && !disp_ack) begin
                // queue is full so writeback may drain again
                if (bp_count > QUEUE_DEPTH + 1) begin
                    value_errors++;
                    $display("error at %0t: dispatches under stall got %0d, expected at most %0d",
                             $time, bp_count, QUEUE_DEPTH + 1);
                end
                bp_active  = 1'b0;
                bp_blocked = 1'b1;
                stall_wb   = 1'b0;
            end
        end while (!disp_ack && waited < HS_TIMEOUT);
        if (!disp_ack) begin
            timeout_errors++;
            $display("timeout: dispatch of tag %0d was never acknowledged", op.insn_tag);
        end else if (bp_active) begin
            bp_count++;
        end
        disp_req = 1'b0;
        waited   = 0;
        while (disp_ack && waited < HS_TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (disp_ack) begin
            timeout_errors++;
            $display("timeout: disp_ack stayed high after request dropped");
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || wb_req || wb_ack) && waited < 10 * HS_TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (exp_q.size() != 0 || wb_req || wb_ack) begin
            timeout_errors++;
            $display("timeout: writeback did not drain with %0d results still missing",
                     exp_q.size());
        end
    endtask

    // writeback consumer with random ack delay
    initial begin : wb_consumer
        int         idle;
        int         delay;
        int         waited;
        ls_result_t exp;
        idle = 0;
        while (!all_done) begin
            @(negedge clock);
            if (!rst && wb_req && !stall_wb) begin
                idle = 0;
                if (exp_q.size() == 0) begin
                    value_errors++;
                    $display("writeback with tag %0d arrived with nothing expected",
                             wb_result.tag);
                end else begin
                    exp = exp_q.pop_front();
                    check_result("wb_result", wb_result, exp);
                end
                delay = random_bits(2);
                repeat (delay) @(negedge clock);
                wb_ack = 1'b1;
                waited = 0;
                while (wb_req && waited < HS_TIMEOUT) begin
                    @(negedge clock);
                    waited++;
                end
                if (wb_req) begin
                    timeout_errors++;
                    $display("timeout: wb_req stayed high after wb_ack");
                end
                wb_ack = 1'b0;
            end else if (exp_q.size() != 0 && !stall_wb) begin
                idle++;
                if (idle == IDLE_LIMIT) begin
                    timeout_errors++;
                    $display("timeout: no writeback for %0d cycles", IDLE_LIMIT);
                end
            end else begin
                idle = 0;
            end
        end
    end

    initial begin
        for (int i = 0; i < MEM_WORDS*4; i++) begin
            model_mem[i] = 8'h00; // RAM starts zeroed
        end
        rst       = 1'b1;
        disp_req  = 1'b0;
        disp_insn = '0;
        wb_ack    = 1'b0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        check_bit("disp_ack", disp_ack, 1'b0);
        check_bit("wb_req", wb_req, 1'b0);
        check_result("wb_result", wb_result, '0);
        check_command("mem_command", UUT.mem_command, bus_none);
        rst = 1'b0;

        for (int i = 0; i < NUM_OPS; i++) begin
            if (i == BP_START) begin
                wait_drained();
                stall_wb  = 1'b1;
                bp_count  = 0;
                bp_active = 1'b1;
            end
            dispatch(OPS[i]);
        end
        wait_drained();
        if (!bp_blocked) begin
            value_errors++;
            $display("dispatch never stalled while writeback was withheld");
        end
        all_done = 1'b1;

        if (value_errors == 0 && timeout_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $display("value errors %0d, timeout errors %0d", value_errors, timeout_errors);
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MEM_WORDS   = 256,
    parameter int MISS_CYCLES = 4
) (
    input  wire logic              clock,
    input  wire logic              rst,
    input  wire logic              disp_req,
    output logic                   disp_ack,
    input  wire lsu_pkg::ls_insn_t disp_insn,
    output logic                   wb_req,
    input  wire logic              wb_ack,
    output lsu_pkg::ls_result_t    wb_result
);
    import lsu_pkg::*;

    ls_insn_t        head;
    logic            head_valid;
    logic            head_take;
    bus_command_t    mem_command;
    logic [XLEN-1:0] mem_addr;
    mem_size_t       mem_size;
    logic [XLEN-1:0] mem_wdata;
    logic            mem_hit;
    logic [XLEN-1:0] mem_rdata;

    ls_queue #(
        .DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clock      (clock),
        .rst        (rst),
        .disp_req   (disp_req),
        .disp_ack   (disp_ack),
        .disp_insn  (disp_insn),
        .head_valid (head_valid),
        .head       (head),
        .head_take  (head_take)
    );

    ls_unit u_unit (
        .clock       (clock),
        .rst         (rst),
        .head_valid  (head_valid),
        .head        (head),
        .head_take   (head_take),
        .mem_command (mem_command),
        .mem_addr    (mem_addr),
        .mem_size    (mem_size),
        .mem_wdata   (mem_wdata),
        .mem_hit     (mem_hit),
        .mem_rdata   (mem_rdata),
        .wb_req      (wb_req),
        .wb_ack      (wb_ack),
        .wb_result   (wb_result)
    );

    data_mem #(
        .MEM_WORDS   (MEM_WORDS),
        .MISS_CYCLES (MISS_CYCLES)
    ) u_mem (
        .clock       (clock),
        .rst         (rst),
        .mem_command (mem_command),
        .mem_addr    (mem_addr),
        .mem_size    (mem_size),
        .mem_wdata   (mem_wdata),
        .mem_hit     (mem_hit),
        .mem_rdata   (mem_rdata)
    );

endmodule

`default_nettype wire

// File: hdl/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem #(
    parameter int MEM_WORDS   = 256,
    parameter int MISS_CYCLES = 4
) (
    input  wire logic                     clock,
    input  wire logic                     rst,
    input  wire lsu_pkg::bus_command_t    mem_command,
    input  wire logic [lsu_pkg::XLEN-1:0] mem_addr,
    input  wire lsu_pkg::mem_size_t       mem_size,
    input  wire logic [lsu_pkg::XLEN-1:0] mem_wdata,
    output logic                          mem_hit,
    output logic [lsu_pkg::XLEN-1:0]      mem_rdata
);
    import lsu_pkg::*;

    localparam int WORD_AW  = $clog2(MEM_WORDS);
    localparam int CNT_W    = $clog2(MISS_CYCLES + 1);
    localparam int LINE_LSB = 4; // 4 words per line
    localparam logic [CNT_W-1:0] MISS_LOAD = CNT_W'(MISS_CYCLES);
    localparam logic [CNT_W-1:0] MISS_LAST = CNT_W'(1);

    logic [XLEN-1:0]          ram [MEM_WORDS];
    logic [WORD_AW-1:0]       word_idx;
    logic [3:0]               byte_en;
    logic [XLEN-1:LINE_LSB]   line_tag;
    logic                     line_valid;
    logic                     line_hit;
    logic [CNT_W-1:0]         miss_cnt;
    logic                     new_cmd;
    logic                     start_miss;
    logic                     do_access;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            ram[i] = '0; // simulation only
        end
    end

    assign word_idx = mem_addr[WORD_AW+1:2];
    assign line_hit = line_valid && (line_tag == mem_addr[XLEN-1:LINE_LSB]);

    // command still up during the hit cycle, ignore it there
    assign new_cmd    = !mem_hit && (miss_cnt == '0) && (mem_command != bus_none);
    assign start_miss = new_cmd && !line_hit;
    assign do_access  = (new_cmd && line_hit) || (miss_cnt == MISS_LAST);

    always_comb begin
        case (mem_size)
            byte_size: byte_en = 4'b0001 << mem_addr[1:0];
            half_size: byte_en = mem_addr[1] ? 4'b1100 : 4'b0011;
            default:   byte_en = 4'b1111;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            mem_hit    <= 1'b0;
            line_valid <= 1'b0;
            line_tag   <= '0;
            miss_cnt   <= '0;
        end else begin
            mem_hit <= do_access;
            if (start_miss) begin
                line_tag   <= mem_addr[XLEN-1:LINE_LSB];
                line_valid <= 1'b1;
                miss_cnt   <= MISS_LOAD;
            end else if (miss_cnt != '0) begin
                miss_cnt <= miss_cnt - 1'b1;
            end
        end
    end

    // write lands on the same edge that raises mem_hit
    always_ff @(posedge clock) begin
        if (do_access) begin
            mem_rdata <= ram[word_idx];
            if (mem_command == bus_store) begin
                for (int b = 0; b < 4; b++) begin
                    if (byte_en[b]) begin
                        ram[word_idx][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/ls_unit.sv
`timescale 1ns/10ps
`default_nettype none

module ls_unit (
    input  wire logic                     clock,
    input  wire logic                     rst,
    input  wire logic                     head_valid,
    input  wire lsu_pkg::ls_insn_t        head,
    output logic                          head_take,
    output lsu_pkg::bus_command_t         mem_command,
    output logic [lsu_pkg::XLEN-1:0]      mem_addr,
    output lsu_pkg::mem_size_t            mem_size,
    output logic [lsu_pkg::XLEN-1:0]      mem_wdata,
    input  wire logic                     mem_hit,
    input  wire logic [lsu_pkg::XLEN-1:0] mem_rdata,
    output logic                          wb_req,
    input  wire logic                     wb_ack,
    output lsu_pkg::ls_result_t           wb_result
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_writeback,
        st_release
    } unit_state_t;

    unit_state_t     state;
    ls_insn_t        insn;      // instruction in flight
    logic [1:0]      lane;
    logic [7:0]      byte_lane;
    logic [15:0]     half_lane;
    logic            sign_bit;
    logic [XLEN-1:0] load_data;

    // all derived from the latched insn, so stable while busy
    assign mem_addr    = insn.value_src1 + insn.imm;
    assign mem_size    = mem_size_t'(insn.func3[1:0]);
    assign mem_command = (state == st_access) ? insn.mem_command : bus_none;
    assign wb_req      = (state == st_writeback);
    assign lane        = mem_addr[1:0];

    // store data copied into every lane it could land in
    always_comb begin
        case (mem_size)
            byte_size: mem_wdata = {4{insn.value_src2[7:0]}};
            half_size: mem_wdata = {2{insn.value_src2[15:0]}};
            default:   mem_wdata = insn.value_src2;
        endcase
    end

    // lane select and extension on the returned word
    always_comb begin
        byte_lane = mem_rdata[{lane, 3'b000} +: 8];
        half_lane = mem_rdata[{lane[1], 4'b0000} +: 16];
        sign_bit  = 1'b0;
        case (mem_size)
            byte_size: begin
                sign_bit  = (insn.func == ls_load) && byte_lane[7];
                load_data = {{(XLEN-8){sign_bit}}, byte_lane};
            end
            half_size: begin
                sign_bit  = (insn.func == ls_load) && half_lane[15];
                load_data = {{(XLEN-16){sign_bit}}, half_lane};
            end
            default: load_data = mem_rdata;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= st_idle;
            head_take <= 1'b0;
            wb_result <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (head_take) begin // queue pops on this edge
                        head_take <= 1'b0;
                        state     <= st_access;
                    end else if (head_valid) begin
                        head_take <= 1'b1;
                    end
                end
                st_access: begin
                    if (mem_hit) begin
                        wb_result.tag <= insn.insn_tag;
                        if (insn.mem_command == bus_load) begin
                            wb_result.data <= load_data;
                        end else begin
                            wb_result.data <= '0;
                        end
                        state <= st_writeback;
                    end
                end
                st_writeback: begin
                    if (wb_ack) begin
                        state <= st_release;
                    end
                end
                st_release: begin
                    if (!wb_ack) begin // wb_req already low here
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (head_take) begin
            insn <= head;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ls_queue.sv
`timescale 1ns/10ps
`default_nettype none

module ls_queue #(
    parameter int DEPTH = 4
) (
    input  wire logic              clock,
    input  wire logic              rst,
    input  wire logic              disp_req,
    output logic                   disp_ack,
    input  wire lsu_pkg::ls_insn_t disp_insn,
    output logic                   head_valid,
    output lsu_pkg::ls_insn_t      head,
    input  wire logic              head_take
);
    import lsu_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);

    typedef enum logic {
        disp_wait,
        disp_hold
    } disp_state_t;

    disp_state_t      disp_state;
    ls_insn_t         entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full       = (count == FULL_COUNT);
    assign head_valid = (count != '0);
    assign head       = entries[rd_ptr]; // oldest entry

    // take one entry per handshake, only with room left
    assign push = (disp_state == disp_wait) && disp_req && !full;
    assign pop  = head_take && head_valid;

    // four-phase dispatch side
    always_ff @(posedge clock) begin
        if (rst) begin
            disp_state <= disp_wait;
            disp_ack   <= 1'b0;
        end else begin
            case (disp_state)
                disp_wait: begin
                    if (push) begin
                        disp_ack   <= 1'b1;
                        disp_state <= disp_hold;
                    end
                end
                disp_hold: begin
                    if (!disp_req) begin // source has let go
                        disp_ack   <= 1'b0;
                        disp_state <= disp_wait;
                    end
                end
                default: disp_state <= disp_wait;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[wr_ptr] <= disp_insn;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    parameter int XLEN = 32;
    parameter int TAG_LEN = 5; // rob tag

    typedef enum logic [1:0] {
        bus_none  = 2'b00,
        bus_load  = 2'b01,
        bus_store = 2'b10
    } bus_command_t;

    // same encoding as func3[1:0]
    typedef enum logic [1:0] {
        byte_size = 2'b00,
        half_size = 2'b01,
        word_size = 2'b10
    } mem_size_t;

    typedef enum logic {
        ls_load  = 1'b0, // sign extend
        ls_loadu = 1'b1  // zero extend
    } ls_func_t;

    // one memory instruction as dispatched
    typedef struct packed {
        bus_command_t        mem_command;
        ls_func_t            func;
        logic [2:0]          func3;
        logic [XLEN-1:0]     value_src1; // base
        logic [XLEN-1:0]     value_src2; // store data
        logic [XLEN-1:0]     imm;
        logic [TAG_LEN-1:0]  insn_tag;
    } ls_insn_t;

    // writeback payload, data is zero for stores
    typedef struct packed {
        logic [TAG_LEN-1:0]  tag;
        logic [XLEN-1:0]     data;
    } ls_result_t;

endpackage

`default_nettype wire
